//--- arrayHeap.f
+incdir+source
+incdir+test
source/heapPkg.sv
source/heapCmdIf.sv
source/heapRspIf.sv
source/heapAllocator.sv
source/heapArrayEngine.sv
source/heapResponseBuffer.sv
source/arrayHeap.sv
test/arrayHeapTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the array heap testbench with Verilator, run it and judge the log

set -u
cd "$(dirname "$0")" || exit 1

buildDir=build
logFile="$buildDir/sim.log"
failMessage="Checks failed"

if ! mkdir -p "$buildDir"; then
  echo "Cannot create $buildDir"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
    -f arrayHeap.f --top-module arrayHeapTb \
    -Mdir "$buildDir/obj" -o arrayHeapSim; then
  echo "Verilator build failed"
  exit 1
fi

"$buildDir/obj/arrayHeapSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ "$runStatus" -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "$failMessage" "$logFile"; then
  echo "Result: FAIL"
  exit 1
fi
echo "Result: PASS"
exit 0

//--- source/arrayHeap.sv
// Array heap top level
// Allocator, array engine and response FIFO in one in-order pipeline

`timescale 1ns/1ps
`default_nettype none

module arrayHeap (
  input  wire logic                  clock,
  input  wire logic                  resetN,
  input  wire logic                  cmdValid,
  output wire logic                  cmdReady,
  input  wire heapPkg::heapOpT       cmdOp,
  input  wire heapPkg::arrayIdT      cmdArray,
  input  wire heapPkg::elementIndexT cmdIndex,
  input  wire heapPkg::heapDataT     cmdData,
  output wire logic                  rspValid,
  input  wire logic                  rspReady,
  output wire heapPkg::heapDataT     rspData,
  output wire heapPkg::heapErrorT    rspError
);

  heapCmdIf cmdBus ();  // Allocator to engine
  heapRspIf rspBus ();  // Engine to FIFO

  // --------------------------------------------------------------------------
  // Pipeline stages
  heapAllocator allocator (
    .clock    (clock),
    .resetN   (resetN),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmdOp    (cmdOp),
    .cmdArray (cmdArray),
    .cmdIndex (cmdIndex),
    .cmdData  (cmdData),
    .toEngine (cmdBus.allocator)
  );

  heapArrayEngine engine (
    .clock         (clock),
    .resetN        (resetN),
    .fromAllocator (cmdBus.engine),
    .toBuffer      (rspBus.engine)
  );

  heapResponseBuffer responses (
    .clock      (clock),
    .resetN     (resetN),
    .fromEngine (rspBus.buffer),
    .rspValid   (rspValid),
    .rspReady   (rspReady),
    .rspData    (rspData),
    .rspError   (rspError)
  );

endmodule

`default_nettype wire

//--- source/heapAllocator.sv
// Heap allocator, the input stage of the array heap
// Hands out and takes back arrays, checks ownership of every array command
// and registers one checked command per cycle toward the engine

`timescale 1ns/1ps
`default_nettype none

`include "heap_cfg.svh"

module heapAllocator (
  input  wire logic                   clock,
  input  wire logic                   resetN,
  input  wire logic                   cmdValid,
  output logic                        cmdReady,
  input  wire heapPkg::heapOpT        cmdOp,
  input  wire heapPkg::arrayIdT       cmdArray,
  input  wire heapPkg::elementIndexT  cmdIndex,
  input  wire heapPkg::heapDataT      cmdData,
  heapCmdIf.allocator                 toEngine
);
  import heapPkg::*;

  localparam int ArrayCount = 1 << `HEAP_ARRAY_BITS;

  logic [ArrayCount-1:0]     allocated;             // One flag per array
  arrayIdT                   freeStack [ArrayCount]; // Freed numbers, reused first
  logic [`HEAP_ARRAY_BITS:0] freeTop;               // Entries on free stack
  logic [`HEAP_ARRAY_BITS:0] newCount;              // Arrays ever handed out
  logic                      accept;
  logic                      checked;               // Command passed its checks
  arrayIdT                   grant;                 // Array sent to the engine
  heapErrorT                 checkError;

  assign cmdReady = !toEngine.valid || toEngine.ready; // Empty or draining
  assign accept   = cmdValid && cmdReady;
  assign checked  = accept && (checkError == errNone);

  // --------------------------------------------------------------------------
  // Grant and ownership check
  always_comb begin
    grant      = cmdArray;
    checkError = errNone;
    case (cmdOp)
      opClearAll: ;                                // Always allowed
      opAlloc: begin
        if (freeTop != '0) begin
          grant = freeStack[arrayIdT'(freeTop - 1'b1)]; // Top of free stack
        end else if (newCount != ArrayCount) begin
          grant = arrayIdT'(newCount);             // Next never-used array
        end else begin
          checkError = errNoArrays;
        end
      end
      default: begin
        if (!allocated[cmdArray]) begin            // Catches double free too
          checkError = errNotAllocated;
        end
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Allocation state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated      <= '0;
      freeTop        <= '0;
      newCount       <= '0;
      toEngine.valid <= 1'b0;
    end else begin
      if (cmdReady) begin
        toEngine.valid <= cmdValid;                // Load or drain
      end
      if (checked) begin
        case (cmdOp)
          opClearAll: begin
            allocated <= '0;
            freeTop   <= '0;
            newCount  <= '0;
          end
          opAlloc: begin
            allocated[grant] <= 1'b1;
            if (freeTop != '0) begin
              freeTop <= freeTop - 1'b1;           // Pop free stack
            end else begin
              newCount <= newCount + 1'b1;
            end
          end
          opFree: begin
            allocated[cmdArray] <= 1'b0;
            freeTop             <= freeTop + 1'b1; // Push free stack
          end
          default: ;
        endcase
      end
    end
  end

  // Free stack body and command register
  always_ff @(posedge clock) begin
    if (checked && cmdOp == opFree) begin
      freeStack[arrayIdT'(freeTop)] <= cmdArray;
    end
    if (accept) begin
      toEngine.op    <= cmdOp;
      toEngine.array <= grant;
      toEngine.index <= cmdIndex;
      toEngine.data  <= cmdData;
      toEngine.error <= checkError;
    end
  end

endmodule

`default_nettype wire

//--- source/heapArrayEngine.sv
// Heap array engine, the processing stage of the array heap
// Holds element memory and array sizes, executes each command on the edge
// that accepts it and passes the result through an output register

`timescale 1ns/1ps
`default_nettype none

`include "heap_cfg.svh"

module heapArrayEngine (
  input  wire logic clock,
  input  wire logic resetN,
  heapCmdIf.engine  fromAllocator,
  heapRspIf.engine  toBuffer
);
  import heapPkg::*;

  localparam int ArrayCount  = 1 << `HEAP_ARRAY_BITS;
  localparam int ArrayLength = 1 << `HEAP_INDEX_BITS;

  heapDataT     memory [ArrayCount][ArrayLength]; // Arrays in fixed blocks
  arraySizeT    sizes  [ArrayCount];              // Current size of each array

  logic         accept;
  logic         exValid;       // Result stage holds a response
  logic         exMove;        // Result stage may advance
  heapDataT     exData;
  heapErrorT    exError;
  arraySizeT    curSize;
  heapDataT     element;       // Element at command index
  heapDataT     topElement;    // Last element within size
  logic         inBounds;
  logic         needsIndex;    // Command reads an indexed element
  arraySizeT    lessCount;
  arraySizeT    greaterCount;
  arraySizeT    lastMatch;
  heapDataT     result;
  heapErrorT    error;
  logic         writeElement;
  elementIndexT writeIndex;
  heapDataT     writeValue;
  logic         writeSize;
  arraySizeT    newSize;

  assign exMove              = !toBuffer.valid || toBuffer.ready;
  assign fromAllocator.ready = !exValid || exMove;
  assign accept              = fromAllocator.valid && fromAllocator.ready;

  assign curSize    = sizes[fromAllocator.array];
  assign element    = memory[fromAllocator.array][fromAllocator.index];
  assign topElement = memory[fromAllocator.array][elementIndexT'(curSize - 1'b1)];
  assign inBounds   = arraySizeT'(fromAllocator.index) < curSize;
  assign needsIndex = fromAllocator.op inside {opRead, opAdd, opAddAfter, opSubtract,
                                               opSubAfter, opAnd, opOr, opXor};

  // --------------------------------------------------------------------------
  // Searches over the elements within the size
  always_comb begin
    lessCount    = '0;
    greaterCount = '0;
    lastMatch    = '0;
    for (int i = 0; i < ArrayLength; i++) begin
      if (arraySizeT'(i) < curSize) begin
        if (memory[fromAllocator.array][i] < fromAllocator.data) begin
          lessCount = lessCount + 1'b1;
        end
        if (memory[fromAllocator.array][i] > fromAllocator.data) begin
          greaterCount = greaterCount + 1'b1;
        end
        if (memory[fromAllocator.array][i] == fromAllocator.data) begin
          lastMatch = arraySizeT'(i + 1);          // Last match wins
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Command decode
  always_comb begin
    result       = '0;
    error        = fromAllocator.error;
    writeElement = 1'b0;
    writeIndex   = fromAllocator.index;
    writeValue   = fromAllocator.data;
    writeSize    = 1'b0;
    newSize      = curSize;
    if (error == errNone) begin
      case (fromAllocator.op)
        opAlloc: begin
          writeSize = 1'b1;                        // Fresh array starts empty
          newSize   = '0;
          result    = heapDataT'(fromAllocator.array);
        end
        opWrite: begin
          writeElement = 1'b1;
          result       = fromAllocator.data;
          if (!inBounds) begin
            writeSize = 1'b1;                      // Extend to cover the index
            newSize   = arraySizeT'(fromAllocator.index) + 1'b1;
          end
        end
        opRead:    result = element;
        opSize:    result = heapDataT'(curSize);
        opLess:    result = heapDataT'(lessCount);
        opGreater: result = heapDataT'(greaterCount);
        opIndex:   result = heapDataT'(lastMatch);
        opPush: begin
          if (curSize == ArrayLength) begin
            error = errFull;
          end else begin
            writeElement = 1'b1;
            writeIndex   = elementIndexT'(curSize);
            writeSize    = 1'b1;
            newSize      = curSize + 1'b1;
            result       = fromAllocator.data;     // Echo the pushed value
          end
        end
        opPop: begin
          if (curSize == '0) begin
            error = errEmpty;
          end else begin
            writeSize = 1'b1;
            newSize   = curSize - 1'b1;
            result    = topElement;
          end
        end
        opAdd, opAddAfter: begin
          writeElement = 1'b1;
          writeValue   = element + fromAllocator.data;
        end
        opSubtract, opSubAfter: begin
          writeElement = 1'b1;
          writeValue   = element - fromAllocator.data;
        end
        opAnd: begin
          writeElement = 1'b1;
          writeValue   = element & fromAllocator.data;
        end
        opOr: begin
          writeElement = 1'b1;
          writeValue   = element | fromAllocator.data;
        end
        opXor: begin
          writeElement = 1'b1;
          writeValue   = element ^ fromAllocator.data;
        end
        default: ;                                 // Free and ClearAll give zero
      endcase
      case (fromAllocator.op)
        opAdd, opSubtract, opAnd, opOr, opXor: result = writeValue;
        opAddAfter, opSubAfter:                result = element;
        default: ;
      endcase
      if (needsIndex && !inBounds) begin
        error        = errOutOfBounds;
        writeElement = 1'b0;
      end
    end
    if (error != errNone) begin
      result = '0;                                 // Errors carry no data
    end
  end

  // --------------------------------------------------------------------------
  // State update, result stage and output register
  always_ff @(posedge clock) begin
    if (accept && writeElement) begin
      memory[fromAllocator.array][writeIndex] <= writeValue;
    end
    if (accept && writeSize) begin
      sizes[fromAllocator.array] <= newSize;
    end
    if (accept) begin
      exData  <= result;
      exError <= error;
    end
    if (exValid && exMove) begin
      toBuffer.data  <= exData;
      toBuffer.error <= exError;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      exValid        <= 1'b0;
      toBuffer.valid <= 1'b0;
    end else begin
      if (fromAllocator.ready) begin
        exValid <= fromAllocator.valid;
      end
      if (exMove) begin
        toBuffer.valid <= exValid;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/heapCmdIf.sv
// Checked command bus from the allocator to the array engine
// A nonzero error means the engine answers without touching state

`timescale 1ns/1ps
`default_nettype none

interface heapCmdIf;
  import heapPkg::*;

  logic         valid;  // Command held in allocator register
  logic         ready;  // Engine can take it
  heapOpT       op;
  arrayIdT      array;  // Granted number for Alloc
  elementIndexT index;
  heapDataT     data;
  heapErrorT    error;  // Ownership check result

  modport allocator (
    output valid, op, array, index, data, error,
    input  ready
  );

  modport engine (
    input  valid, op, array, index, data, error,
    output ready
  );

endinterface

`default_nettype wire

//--- source/heapPkg.sv
// Array heap package
// Width types, command codes and error codes shared by the heap pipeline

`default_nettype none

`include "heap_cfg.svh"

package heapPkg;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0] elementIndexT; // Position in an array
  typedef logic [`HEAP_INDEX_BITS:0]   arraySizeT;    // Element count 0..8
  typedef logic [`HEAP_DATA_BITS-1:0]  heapDataT;     // Element data

  // --------------------------------------------------------------------------
  // Command codes
  typedef enum logic [4:0] {
    opClearAll = 5'd1,   // Forget every allocation
    opWrite    = 5'd2,
    opRead     = 5'd3,
    opSize     = 5'd4,
    opIndex    = 5'd7,   // One plus last matching position
    opLess     = 5'd8,   // Count of elements below data
    opGreater  = 5'd9,   // Count of elements above data
    opPush     = 5'd14,
    opPop      = 5'd15,
    opAlloc    = 5'd18,
    opFree     = 5'd19,
    opAdd      = 5'd20,  // Returns new value
    opAddAfter = 5'd21,  // Returns old value
    opSubtract = 5'd22,
    opSubAfter = 5'd23,
    opOr       = 5'd28,
    opXor      = 5'd29,
    opAnd      = 5'd30
  } heapOpT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,  // Array not currently allocated
    errOutOfBounds  = 3'd2,  // Index at or past the size
    errEmpty        = 3'd3,  // Pop on empty array
    errFull         = 3'd4,  // Push on full array
    errNoArrays     = 3'd5   // Nothing left to allocate
  } heapErrorT;

endpackage

`default_nettype wire

//--- source/heapResponseBuffer.sv
// Heap response buffer, the output stage of the array heap
// Small FIFO of results that holds the engine back when full

`timescale 1ns/1ps
`default_nettype none

`include "heap_cfg.svh"

module heapResponseBuffer (
  input  wire logic        clock,
  input  wire logic        resetN,
  heapRspIf.buffer         fromEngine,
  output logic             rspValid,
  input  wire logic        rspReady,
  output heapPkg::heapDataT  rspData,
  output heapPkg::heapErrorT rspError
);
  import heapPkg::*;

  localparam int Depth   = `HEAP_RSP_DEPTH;
  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;

  heapDataT                   dataQ  [Depth];
  heapErrorT                  errorQ [Depth];
  logic [PtrBits-1:0]         writePtr;
  logic [PtrBits-1:0]         readPtr;
  logic [$clog2(Depth+1)-1:0] count;       // Entries held
  logic                       push;
  logic                       pop;

  // Step a pointer with wrap at the last entry
  function automatic logic [PtrBits-1:0] advance(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign fromEngine.ready = (count != Depth);
  assign rspValid         = (count != '0);
  assign rspData          = dataQ[readPtr];  // Head entry
  assign rspError         = errorQ[readPtr];
  assign push             = fromEngine.valid && fromEngine.ready;
  assign pop              = rspValid && rspReady;

  always_ff @(posedge clock) begin
    if (push) begin
      dataQ[writePtr]  <= fromEngine.data;
      errorQ[writePtr] <= fromEngine.error;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        writePtr <= advance(writePtr);
      end
      if (pop) begin
        readPtr <= advance(readPtr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                           // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/heapRspIf.sv
// Result bus from the array engine to the response FIFO

`timescale 1ns/1ps
`default_nettype none

interface heapRspIf;
  import heapPkg::*;

  logic      valid;  // Result waiting in engine output register
  logic      ready;  // FIFO has space
  heapDataT  data;
  heapErrorT error;

  modport engine (
    output valid, data, error,
    input  ready
  );

  modport buffer (
    input  valid, data, error,
    output ready
  );

endinterface

`default_nettype wire

//--- source/heap_cfg.svh
// Array heap configuration
// Bit widths of array numbers, indices and data, plus the response queue depth

`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

`define HEAP_ARRAY_BITS 2   // Array number width, four arrays
`define HEAP_INDEX_BITS 3   // Element index width, eight elements per array
`define HEAP_DATA_BITS  12  // Element and result width
`define HEAP_RSP_DEPTH  2   // Response FIFO entries

`endif

//--- test/heapRefModel.svh
// Reference model of the array heap
// Mirrors allocation and element state and predicts data and error per command

`ifndef HEAP_REF_MODEL_SVH
`define HEAP_REF_MODEL_SVH

logic      modelAllocated [4];     // Array currently owned
arrayIdT   modelFreeList  [4];     // Freed numbers, last freed on top
int        modelFreeCount;
int        modelUsedCount;         // Arrays ever handed out since clear
arraySizeT modelSize      [4];
heapDataT  modelMemory    [4][8];

task automatic resetModel();
  for (int a = 0; a < 4; a++) begin
    modelAllocated[a] = 1'b0;
    modelSize[a]      = '0;
    for (int e = 0; e < 8; e++) begin
      modelMemory[a][e] = '0;
    end
  end
  modelFreeCount = 0;
  modelUsedCount = 0;
endtask

function automatic void predictResult(input heapOpT op, input arrayIdT array,
                                      input elementIndexT index, input heapDataT data,
                                      output heapDataT expectData,
                                      output heapErrorT expectError);
  arraySizeT size;
  arrayIdT   granted;
  heapDataT  oldValue;
  heapDataT  newValue;
  expectData  = '0;
  expectError = errNone;
  size        = modelSize[array];
  oldValue    = modelMemory[array][index];
  if (op == opClearAll) begin
    for (int a = 0; a < 4; a++) begin
      modelAllocated[a] = 1'b0;
    end
    modelFreeCount = 0;
    modelUsedCount = 0;
    return;
  end
  if (op == opAlloc) begin
    if (modelFreeCount > 0) begin                  // Reuse most recent free
      modelFreeCount--;
      granted = modelFreeList[modelFreeCount];
    end else if (modelUsedCount < 4) begin
      granted = arrayIdT'(modelUsedCount);
      modelUsedCount++;
    end else begin
      expectError = errNoArrays;
      return;
    end
    modelAllocated[granted] = 1'b1;
    modelSize[granted]      = '0;
    expectData              = heapDataT'(granted);
    return;
  end
  if (!modelAllocated[array]) begin
    expectError = errNotAllocated;
    return;
  end
  case (op)
    opFree: begin
      modelAllocated[array]         = 1'b0;
      modelFreeList[modelFreeCount] = array;
      modelFreeCount++;
    end
    opWrite: begin
      modelMemory[array][index] = data;
      if (arraySizeT'(index) >= size) begin
        modelSize[array] = arraySizeT'(index) + 1'b1;
      end
      expectData = data;
    end
    opSize: expectData = heapDataT'(size);
    opLess, opGreater, opIndex: begin
      for (int e = 0; e < 8; e++) begin
        if (e < int'(size)) begin
          if (op == opLess && modelMemory[array][e] < data) expectData++;
          if (op == opGreater && modelMemory[array][e] > data) expectData++;
          if (op == opIndex && modelMemory[array][e] == data) expectData = heapDataT'(e + 1);
        end
      end
    end
    opPush: begin
      if (size == 4'd8) begin
        expectError = errFull;
      end else begin
        modelMemory[array][elementIndexT'(size)] = data;
        modelSize[array] = size + 1'b1;
        expectData       = data;
      end
    end
    opPop: begin
      if (size == '0) begin
        expectError = errEmpty;
      end else begin
        modelSize[array] = size - 1'b1;
        expectData       = modelMemory[array][elementIndexT'(size - 1'b1)];
      end
    end
    default: begin                                 // Read and element operations
      if (arraySizeT'(index) >= size) begin
        expectError = errOutOfBounds;
      end else begin
        case (op)
          opAdd, opAddAfter:      newValue = oldValue + data;
          opSubtract, opSubAfter: newValue = oldValue - data;
          opAnd:                  newValue = oldValue & data;
          opOr:                   newValue = oldValue | data;
          opXor:                  newValue = oldValue ^ data;
          default:                newValue = oldValue;
        endcase
        modelMemory[array][index] = newValue;
        expectData = (op == opAddAfter || op == opSubAfter) ? oldValue : newValue;
      end
    end
  endcase
endfunction

`endif

//--- test/arrayHeapTb.sv
// Testbench of the array heap
// Directed and LCG driven command streams checked against a reference model

`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb;
  import heapPkg::*;

  localparam int ClockPeriod      = 8;
  localparam int ResetCycles      = 5;
  localparam int RandomSteps      = 200;
  localparam int DirectedCommands = 68;  // Directed commands of all tests
  localparam int CyclesPerCommand = 20;
  localparam int TimeoutCycles    = (DirectedCommands + RandomSteps) * CyclesPerCommand
                                    + ResetCycles;

  logic         clock;
  logic         resetN;
  logic         cmdValid;
  logic         cmdReady;
  heapOpT       cmdOp;
  arrayIdT      cmdArray;
  elementIndexT cmdIndex;
  heapDataT     cmdData;
  logic         rspValid;
  logic         rspReady = 1'b1;
  heapDataT     rspData;
  heapErrorT    rspError;

  heapDataT     expectedData [$];   // Filled at accept and drained at response
  heapErrorT    expectedError [$];
  int           checkCount;
  int           errorCount;
  int           testStartErrors;
  string        testName;
  logic         randomReady;        // Back-pressure on the response side
  logic [31:0]  stimSeed;
  logic [31:0]  readySeed;

  heapOpT   elementOps [7] = '{opAdd, opAddAfter, opSubtract, opSubAfter, opAnd, opOr, opXor};
  heapDataT operands   [7] = '{12'd5, 12'd5, 12'd10, 12'd30, 12'h03c, 12'h101, 12'h0ff};
  heapOpT   opTable    [22] = '{opClearAll, opAlloc, opAlloc, opAlloc, opFree, opFree,
                                opWrite, opWrite, opRead, opSize, opPush, opPop, opLess,
                                opGreater, opIndex, opAdd, opAddAfter, opSubtract,
                                opSubAfter, opAnd, opOr, opXor};

  `include "heapRefModel.svh"

  arrayHeap UUT (
    .clock    (clock),
    .resetN   (resetN),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmdOp    (cmdOp),
    .cmdArray (cmdArray),
    .cmdIndex (cmdIndex),
    .cmdData  (cmdData),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData),
    .rspError (rspError)
  );

  always #(ClockPeriod / 2) clock = ~clock;

  // --------------------------------------------------------------------------
  // Random sources
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] drawStim();
    stimSeed = lcgNext(stimSeed);
    return stimSeed[30:15];       // Upper bits spread better
  endfunction

  function automatic logic [2:0] drawReady();
    readySeed = lcgNext(readySeed);
    return readySeed[29:27];
  endfunction

  // --------------------------------------------------------------------------
  // Command side on the falling edge
  task automatic sendCommand(input heapOpT op, input arrayIdT array,
                             input elementIndexT index, input heapDataT data);
    heapDataT  expectData;
    heapErrorT expectError;
    cmdValid = 1'b1;
    cmdOp    = op;
    cmdArray = array;
    cmdIndex = index;
    cmdData  = data;
    while (!cmdReady) @(negedge clock);          // Held until accepted
    predictResult(op, array, index, data, expectData, expectError);
    expectedData.push_back(expectData);
    expectedError.push_back(expectError);
    @(negedge clock);
    cmdValid = 1'b0;
  endtask

  task automatic randomStep();
    heapOpT       op;
    arrayIdT      array;
    elementIndexT index;
    heapDataT     data;
    op    = opTable[drawStim() % 22];
    array = arrayIdT'(drawStim());
    index = elementIndexT'(drawStim());
    data  = heapDataT'(drawStim() % 32);         // Small range so searches hit
    if (op == opWrite && arraySizeT'(index) > modelSize[array]) begin
      index = elementIndexT'(modelSize[array]);  // No gaps of unwritten elements
    end
    sendCommand(op, array, index, data);
  endtask

  // --------------------------------------------------------------------------
  // Response side and comparison
  task automatic checkResponse(input heapDataT expectData, input heapErrorT expectError);
    checkCount++;
    assert (rspData === expectData) else begin
      $display("Mismatch at %0t ns: rspData got %0d expected %0d", $time, rspData,
               expectData);
      errorCount++;
    end
    assert (rspError === expectError) else begin
      $display("Mismatch at %0t ns: rspError got %s expected %s", $time, rspError.name(),
               expectError.name());
      errorCount++;
    end
  endtask

  always @(negedge clock) begin
    rspReady = randomReady ? (drawReady() < 3'd5) : 1'b1;
    if (resetN && rspValid && rspReady) begin    // Transfer on next rising edge
      assert (expectedData.size() != 0) else begin
        $display("Response at %0t ns with no command outstanding", $time);
        errorCount++;
      end
      if (expectedData.size() != 0) begin
        checkResponse(expectedData.pop_front(), expectedError.pop_front());
      end
    end
  end

  task automatic startTest(input string name);
    testName        = name;
    testStartErrors = errorCount;
  endtask

  task automatic finishTest();
    while (expectedData.size() != 0) @(negedge clock);
    if (errorCount == testStartErrors) begin
      $display("Test %s: ok", testName);
    end else begin
      $display("Test %s: FAILED with %0d errors", testName, errorCount - testStartErrors);
    end
  endtask

  // Watchdog
  initial begin
    #(TimeoutCycles * ClockPeriod);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  initial begin
    clock       = 1'b0;
    resetN      = 1'b0;
    cmdValid    = 1'b0;
    cmdOp       = opClearAll;
    cmdArray    = '0;
    cmdIndex    = '0;
    cmdData     = '0;
    randomReady = 1'b0;
    stimSeed    = 32'd32;
    readySeed   = 32'd32;
    checkCount  = 0;
    errorCount  = 0;
    resetModel();
    repeat (ResetCycles) @(negedge clock);
    resetN = 1'b1;
    @(negedge clock);

    startTest("reset state");
    checkCount += 2;
    assert (cmdReady === 1'b1) else begin
      $display("Mismatch at %0t ns: cmdReady got %b expected 1", $time, cmdReady);
      errorCount++;
    end
    assert (rspValid === 1'b0) else begin
      $display("Mismatch at %0t ns: rspValid got %b expected 0", $time, rspValid);
      errorCount++;
    end
    finishTest();

    startTest("write read size");
    sendCommand(opClearAll, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);                // Expect array 0
    for (int i = 0; i < 3; i++) sendCommand(opWrite, 0, i, heapDataT'(100 + 7 * i));
    for (int i = 0; i < 3; i++) sendCommand(opRead, 0, i, 0);
    sendCommand(opSize, 0, 0, 0);
    sendCommand(opRead, 0, 5, 0);                 // Past the size
    finishTest();

    startTest("push pop");
    sendCommand(opClearAll, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);
    for (int i = 0; i < 9; i++) sendCommand(opPush, 0, 0, heapDataT'(200 + i));
    for (int i = 0; i < 9; i++) sendCommand(opPop, 0, 0, 0);
    finishTest();

    startTest("searches");
    sendCommand(opClearAll, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opPush, 0, 0, 10);
    sendCommand(opPush, 0, 0, 20);
    sendCommand(opPush, 0, 0, 30);
    sendCommand(opPush, 0, 0, 20);
    sendCommand(opLess, 0, 0, 20);
    sendCommand(opGreater, 0, 0, 20);
    sendCommand(opIndex, 0, 0, 20);
    sendCommand(opIndex, 0, 0, 7);
    finishTest();

    startTest("element operations");
    sendCommand(opClearAll, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);
    sendCommand(opWrite, 0, 0, 100);
    for (int i = 0; i < 7; i++) begin
      sendCommand(elementOps[i], 0, 0, operands[i]);
      sendCommand(opRead, 0, 0, 0);               // Stored value is the new one
    end
    finishTest();

    startTest("random with back-pressure");
    randomReady = 1'b1;
    sendCommand(opClearAll, 0, 0, 0);
    for (int i = 0; i < 5; i++) sendCommand(opAlloc, 0, 0, 0);  // Fifth finds none
    sendCommand(opFree, 2, 0, 0);
    sendCommand(opFree, 2, 0, 0);                 // Double free
    sendCommand(opAlloc, 0, 0, 0);                // Gets 2 back
    sendCommand(opClearAll, 0, 0, 0);
    sendCommand(opAlloc, 0, 0, 0);
    for (int step = 0; step < RandomSteps; step++) randomStep();
    finishTest();
    randomReady = 1'b0;

    $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
